/* hw/conv_pkg.sv */
package conv_pkg;

    // word widths.
    localparam int data_width = 16;
    localparam int acc_width = 32;

    // layer geometry.
    localparam int ifm_size = 6;
    localparam int kernel_size = 3;
    localparam int num_filters = 2;
    localparam int ofm_size = ifm_size - kernel_size + 1;
    localparam int num_taps = kernel_size * kernel_size;

    // memory depths.
    localparam int ifm_words = ifm_size * ifm_size;
    localparam int wm_words = num_filters * num_taps; // filter * 9 + tap.

    // memory address widths.
    localparam int ifm_addr_width = 6;
    localparam int wm_addr_width = 5;
    localparam int bm_addr_width = 1;

    // sequencer counter widths.
    localparam int filter_cnt_width = 1;
    localparam int ofm_cnt_width = 2;
    localparam int tap_cnt_width = 2; // kernel row and column.

    // host address map, region code in bits 7..6.
    localparam int host_addr_width = 8;
    localparam int region_width = 2;
    localparam int offset_width = host_addr_width - region_width;
    localparam logic [region_width-1:0] region_ifm = 2'd0;
    localparam logic [region_width-1:0] region_wm = 2'd1;
    localparam logic [region_width-1:0] region_bm = 2'd2;

    // output saturation limit.
    localparam int out_max = 32767;

endpackage

/* hw/conv_mem.sv */
module conv_mem #(
    parameter int depth = 36,
    parameter int addr_width = 6
) (
    input  logic                           clk,
    input  logic                           write_en,
    input  logic [addr_width-1:0]          write_addr,
    input  logic [conv_pkg::data_width-1:0] write_data,
    input  logic                           read_en,
    input  logic [addr_width-1:0]          read_addr,
    output logic [conv_pkg::data_width-1:0] read_data
);
    import conv_pkg::*;

    logic [data_width-1:0] mem [depth];

    always_ff @(posedge clk)
    begin
        if (write_en)
        begin
            mem[write_addr] <= write_data;
        end
        if (read_en)
        begin
            read_data <= mem[read_addr]; // holds between reads.
        end
    end

    a_addr_in_range: assert property (@(posedge clk)
        (write_en |-> int'(write_addr) < depth) and (read_en |-> int'(read_addr) < depth));

endmodule

/* hw/conv_load.sv */
module conv_load (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic                                host_write,
    input  logic [conv_pkg::host_addr_width-1:0] host_address,
    input  logic [conv_pkg::data_width-1:0]      host_data,
    input  logic                                busy,
    output logic                                ifm_write_en,
    output logic                                wm_write_en,
    output logic                                bm_write_en,
    output logic [conv_pkg::ifm_addr_width-1:0]  write_addr,
    output logic [conv_pkg::data_width-1:0]      write_data
);
    import conv_pkg::*;

    logic [region_width-1:0] region;
    logic [offset_width-1:0] offset;
    logic                    accept;

    assign region = host_address[host_addr_width-1:offset_width];
    assign offset = host_address[offset_width-1:0];
    assign accept = host_write && !busy; // layer owns the memories while busy.

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            ifm_write_en <= 1'b0;
            wm_write_en  <= 1'b0;
            bm_write_en  <= 1'b0;
        end
        else
        begin
            ifm_write_en <= accept && region == region_ifm && int'(offset) < ifm_words;
            wm_write_en  <= accept && region == region_wm && int'(offset) < wm_words;
            bm_write_en  <= accept && region == region_bm && int'(offset) < num_filters;
        end
    end

    always_ff @(posedge clk)
    begin
        write_addr <= offset[ifm_addr_width-1:0];
        write_data <= host_data;
    end

    // a write taken in the start cycle would land while the layer reads.
    a_idle_writes: assert property (@(posedge clk) disable iff (!arst_n)
        busy |-> !(ifm_write_en || wm_write_en || bm_write_en));

endmodule

/* hw/conv_window_seq.sv */
module conv_window_seq (
    input  logic                               clk,
    input  logic                               arst_n,
    input  logic                               start,
    output logic                               busy,
    output logic                               ifm_read_en,
    output logic [conv_pkg::ifm_addr_width-1:0] ifm_read_addr,
    output logic                               wm_read_en,
    output logic [conv_pkg::wm_addr_width-1:0]  wm_read_addr,
    output logic                               bm_read_en,
    output logic [conv_pkg::bm_addr_width-1:0]  bm_read_addr,
    output logic                               tap_valid,
    output logic                               tap_first,
    output logic                               tap_last,
    output logic                               last_pixel
);
    import conv_pkg::*;

    logic                        run; // taps still being issued.
    logic [filter_cnt_width-1:0] filt;
    logic [ofm_cnt_width-1:0]    orow;
    logic [ofm_cnt_width-1:0]    ocol;
    logic [tap_cnt_width-1:0]    krow;
    logic [tap_cnt_width-1:0]    kcol;
    logic                        tap_start;
    logic                        tap_end;
    logic                        last_issue;
    logic [1:0]                  drain; // mac and activation stages.

    assign tap_start  = krow == '0 && kcol == '0;
    assign tap_end    = int'(krow) == kernel_size - 1 && int'(kcol) == kernel_size - 1;
    assign last_issue = run && tap_end && int'(filt) == num_filters - 1
                        && int'(orow) == ofm_size - 1 && int'(ocol) == ofm_size - 1;

    assign ifm_read_en   = run;
    assign ifm_read_addr = ifm_addr_width'((orow + krow) * ifm_size + ocol + kcol);
    assign wm_read_en    = run;
    assign wm_read_addr  = wm_addr_width'(filt * num_taps + krow * kernel_size + kcol);
    assign bm_read_en    = run && tap_end; // bias lands with the last tap.
    assign bm_read_addr  = bm_addr_width'(filt);

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            busy <= 1'b0;
            run  <= 1'b0;
            filt <= '0;
            orow <= '0;
            ocol <= '0;
            krow <= '0;
            kcol <= '0;
        end
        else if (!busy)
        begin
            busy <= start;
            run  <= start;
            filt <= '0;
            orow <= '0;
            ocol <= '0;
            krow <= '0;
            kcol <= '0;
        end
        else
        begin
            if (drain[1])
            begin
                busy <= 1'b0; // cycle after done.
            end
            if (last_issue)
            begin
                run <= 1'b0;
            end
            if (run)
            begin
                kcol <= int'(kcol) == kernel_size - 1 ? '0 : kcol + 1'b1;
                if (int'(kcol) == kernel_size - 1)
                begin
                    krow <= int'(krow) == kernel_size - 1 ? '0 : krow + 1'b1;
                end
                if (tap_end)
                begin
                    ocol <= ocol + 1'b1; // wraps at 4.
                    if (int'(ocol) == ofm_size - 1)
                    begin
                        orow <= orow + 1'b1;
                        if (int'(orow) == ofm_size - 1)
                        begin
                            filt <= filt + 1'b1;
                        end
                    end
                end
            end
        end
    end

    // tags follow the read data by one cycle.
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            tap_valid  <= 1'b0;
            tap_first  <= 1'b0;
            tap_last   <= 1'b0;
            last_pixel <= 1'b0;
            drain      <= '0;
        end
        else
        begin
            tap_valid  <= run;
            tap_first  <= run && tap_start;
            tap_last   <= run && tap_end;
            last_pixel <= last_issue;
            drain      <= {drain[0], last_pixel};
        end
    end

    // each window is nine taps with no gaps.
    a_window_taps: assert property (@(posedge clk) disable iff (!arst_n)
        tap_first |-> ##(num_taps - 1) tap_last);

endmodule

/* hw/conv_mac.sv */
module conv_mac (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic signed [conv_pkg::data_width-1:0] pixel_in,
    input  logic signed [conv_pkg::data_width-1:0] weight_in,
    input  logic                                tap_valid,
    input  logic                                tap_first,
    input  logic                                tap_last,
    input  logic                                last_pixel,
    output logic signed [conv_pkg::acc_width-1:0]  sum,
    output logic                                sum_valid,
    output logic                                sum_last_pixel
);
    import conv_pkg::*;

    logic signed [2*data_width-1:0] product;
    logic signed [acc_width-1:0]    acc;
    logic signed [acc_width-1:0]    acc_next;

    assign product  = pixel_in * weight_in;
    assign acc_next = tap_first ? acc_width'(product) : acc + acc_width'(product);

    always_ff @(posedge clk)
    begin
        if (tap_valid)
        begin
            acc <= acc_next; // restarts on the first tap.
        end
    end

    // acc holds the full window for one cycle after the last tap.
    assign sum = acc;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            sum_valid      <= 1'b0;
            sum_last_pixel <= 1'b0;
        end
        else
        begin
            sum_valid      <= tap_valid && tap_last;
            sum_last_pixel <= tap_valid && tap_last && last_pixel;
        end
    end

endmodule

/* hw/conv_activate.sv */
module conv_activate (
    input  logic                                  clk,
    input  logic                                  arst_n,
    input  logic signed [conv_pkg::acc_width-1:0]  sum,
    input  logic                                  sum_valid,
    input  logic                                  sum_last_pixel,
    input  logic signed [conv_pkg::data_width-1:0] bias,
    output logic [conv_pkg::data_width-1:0]        pixel_data,
    output logic                                  pixel_valid,
    output logic                                  done
);
    import conv_pkg::*;

    logic signed [acc_width:0] total; // one guard bit.
    logic [data_width-1:0]     clamped;

    assign total = sum + bias;

    always_comb
    begin
        if (total < 0)
        begin
            clamped = '0; // relu.
        end
        else if (total > out_max)
        begin
            clamped = data_width'(out_max);
        end
        else
        begin
            clamped = total[data_width-1:0];
        end
    end

    always_ff @(posedge clk)
    begin
        if (sum_valid)
        begin
            pixel_data <= clamped;
        end
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            pixel_valid <= 1'b0;
            done        <= 1'b0;
        end
        else
        begin
            pixel_valid <= sum_valid;
            done        <= sum_valid && sum_last_pixel;
        end
    end

    // bias was read with the last tap and is still held.
    a_bias_held: assert property (@(posedge clk) disable iff (!arst_n)
        sum_valid |-> $stable(bias));

endmodule

/* hw/conv_layer_top.sv */
module conv_layer_top (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic                                host_write,
    input  logic [conv_pkg::host_addr_width-1:0] host_address,
    input  logic [conv_pkg::data_width-1:0]      host_data,
    input  logic                                start,
    output logic                                busy,
    output logic [conv_pkg::data_width-1:0]      pixel_data,
    output logic                                pixel_valid,
    output logic                                done
);
    import conv_pkg::*;

    logic                      ifm_write_en;
    logic                      wm_write_en;
    logic                      bm_write_en;
    logic [ifm_addr_width-1:0] write_addr;
    logic [data_width-1:0]     write_data;
    logic                      ifm_read_en;
    logic [ifm_addr_width-1:0] ifm_read_addr;
    logic [data_width-1:0]     ifm_read_data;
    logic                      wm_read_en;
    logic [wm_addr_width-1:0]  wm_read_addr;
    logic [data_width-1:0]     wm_read_data;
    logic                      bm_read_en;
    logic [bm_addr_width-1:0]  bm_read_addr;
    logic [data_width-1:0]     bm_read_data;
    logic                      tap_valid;
    logic                      tap_first;
    logic                      tap_last;
    logic                      last_pixel;
    logic [acc_width-1:0]      sum;
    logic                      sum_valid;
    logic                      sum_last_pixel;

    conv_load load_i (.clk(clk), .arst_n(arst_n), .host_write(host_write),
        .host_address(host_address), .host_data(host_data), .busy(busy),
        .ifm_write_en(ifm_write_en), .wm_write_en(wm_write_en), .bm_write_en(bm_write_en),
        .write_addr(write_addr), .write_data(write_data));

    conv_mem #(.depth(ifm_words), .addr_width(ifm_addr_width)) ifm_mem (.clk(clk),
        .write_en(ifm_write_en), .write_addr(write_addr), .write_data(write_data),
        .read_en(ifm_read_en), .read_addr(ifm_read_addr), .read_data(ifm_read_data));

    conv_mem #(.depth(wm_words), .addr_width(wm_addr_width)) wm_mem (.clk(clk),
        .write_en(wm_write_en), .write_addr(write_addr[wm_addr_width-1:0]),
        .write_data(write_data), .read_en(wm_read_en), .read_addr(wm_read_addr),
        .read_data(wm_read_data));

    conv_mem #(.depth(num_filters), .addr_width(bm_addr_width)) bm_mem (.clk(clk),
        .write_en(bm_write_en), .write_addr(write_addr[bm_addr_width-1:0]),
        .write_data(write_data), .read_en(bm_read_en), .read_addr(bm_read_addr),
        .read_data(bm_read_data));

    conv_window_seq seq_i (.clk(clk), .arst_n(arst_n), .start(start), .busy(busy),
        .ifm_read_en(ifm_read_en), .ifm_read_addr(ifm_read_addr),
        .wm_read_en(wm_read_en), .wm_read_addr(wm_read_addr),
        .bm_read_en(bm_read_en), .bm_read_addr(bm_read_addr),
        .tap_valid(tap_valid), .tap_first(tap_first), .tap_last(tap_last),
        .last_pixel(last_pixel));

    conv_mac mac_i (.clk(clk), .arst_n(arst_n), .pixel_in(ifm_read_data),
        .weight_in(wm_read_data), .tap_valid(tap_valid), .tap_first(tap_first),
        .tap_last(tap_last), .last_pixel(last_pixel), .sum(sum), .sum_valid(sum_valid),
        .sum_last_pixel(sum_last_pixel));

    conv_activate act_i (.clk(clk), .arst_n(arst_n), .sum(sum), .sum_valid(sum_valid),
        .sum_last_pixel(sum_last_pixel), .bias(bm_read_data), .pixel_data(pixel_data),
        .pixel_valid(pixel_valid), .done(done));

endmodule

/* include/conv_tb_model.svh */
`ifndef conv_tb_model_svh
`define conv_tb_model_svh

localparam int num_outputs = num_filters * ofm_size * ofm_size;

typedef logic signed [data_width-1:0] word_t;
typedef logic [data_width-1:0] pixel_t;

// signed sum of the nine taps of one window.
function automatic longint window_sum(input word_t ifm [ifm_words],
    input word_t wts [wm_words], input int filter, input int row, input int col);
    longint total;
    int     kr;
    int     kc;
    total = 0;
    for (kr = 0; kr < kernel_size; kr++)
    begin
        for (kc = 0; kc < kernel_size; kc++)
        begin
            total += longint'(ifm[(row + kr) * ifm_size + col + kc])
                   * longint'(wts[filter * num_taps + kr * kernel_size + kc]);
        end
    end
    return total;
endfunction

function automatic pixel_t relu_saturate(input longint value);
    if (value < 0)
    begin
        return '0;
    end
    if (value > out_max)
    begin
        return pixel_t'(out_max);
    end
    return pixel_t'(value);
endfunction

// whole layer, filter-major then row-major.
function automatic void model_layer(input word_t ifm [ifm_words],
    input word_t wts [wm_words], input word_t bias [num_filters],
    output pixel_t ofm [num_outputs]);
    int f;
    int r;
    int c;
    for (f = 0; f < num_filters; f++)
    begin
        for (r = 0; r < ofm_size; r++)
        begin
            for (c = 0; c < ofm_size; c++)
            begin
                ofm[(f * ofm_size + r) * ofm_size + c] =
                    relu_saturate(longint'(bias[f]) + window_sum(ifm, wts, f, r, c));
            end
        end
    end
endfunction

`endif

/* tb/conv_layer_tb.sv */
module conv_layer_tb;
    import conv_pkg::*;

    `include "conv_tb_model.svh"

    localparam int timeout_cycles = 4000; // six runs of ~300 plus ~60 load cycles each.
    localparam int first_pixel_cycles = 12; // start to first pixel_valid.

    logic                       clk;
    logic                       arst_n;
    logic                       host_write;
    logic [host_addr_width-1:0] host_address;
    logic [data_width-1:0]      host_data;
    logic                       start;
    logic                       busy;
    pixel_t                     pixel_data;
    logic                       pixel_valid;
    logic                       done;

    word_t ifm_copy [ifm_words];
    word_t wm_copy [wm_words];
    word_t bias_copy [num_filters];
    int    cycle_count = 0;

    conv_layer_top dut_i (.clk(clk), .arst_n(arst_n), .host_write(host_write),
        .host_address(host_address), .host_data(host_data), .start(start), .busy(busy),
        .pixel_data(pixel_data), .pixel_valid(pixel_valid), .done(done));

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #2 clk = ~clk;
        end
    end

    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count >= timeout_cycles)
        begin
            abort_run("timeout: the layer did not finish within the cycle limit");
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_pixel(input pixel_t actual, input pixel_t expected, input string what);
        if (actual !== expected)
        begin
            abort_run($sformatf("FAILED at time %0t: %s: got %0d, expected %0d",
                $time, what, actual, expected));
        end
    endtask

    task automatic check_flag(input logic actual, input logic expected, input string what);
        if (actual !== expected)
        begin
            abort_run($sformatf("FAILED at time %0t: %s: got %b, expected %b",
                $time, what, actual, expected));
        end
    endtask

    function automatic word_t random_between(input int lo, input int hi);
        return word_t'(lo + int'($urandom_range(hi - lo)));
    endfunction

    task automatic write_word(input logic [region_width-1:0] region, input int offset,
        input word_t value);
        @(negedge clk);
        host_write   = 1'b1;
        host_address = {region, offset_width'(offset)};
        host_data    = value;
    endtask

    task automatic end_writes();
        @(negedge clk);
        host_write = 1'b0;
    endtask

    task automatic load_ifm(input word_t values [ifm_words]);
        int i;
        for (i = 0; i < ifm_words; i++)
        begin
            ifm_copy[i] = values[i];
            write_word(region_ifm, i, values[i]);
        end
        end_writes();
    endtask

    task automatic load_kernels(input word_t values [wm_words]);
        int i;
        for (i = 0; i < wm_words; i++)
        begin
            wm_copy[i] = values[i];
            write_word(region_wm, i, values[i]);
        end
        end_writes();
    endtask

    task automatic load_bias(input word_t values [num_filters]);
        int i;
        for (i = 0; i < num_filters; i++)
        begin
            bias_copy[i] = values[i];
            write_word(region_bm, i, values[i]);
        end
        end_writes();
    endtask

    // disturb drives ifm writes and a second start while the layer is busy.
    task automatic run_layer(input pixel_t expected [num_outputs], input bit disturb);
        int count;
        int cyc;
        int last_cyc;
        count    = 0;
        cyc      = 0;
        last_cyc = 0;
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        check_flag(busy, 1'b1, "busy after start");
        do
        begin
            host_write   = disturb && cyc < 10;
            host_address = {region_ifm, offset_width'(cyc)};
            host_data    = 16'h7fff;
            start        = disturb && cyc == 4;
            @(negedge clk);
            cyc++;
            if (pixel_valid)
            begin
                if (count >= num_outputs)
                begin
                    abort_run("the layer produced more pixels than it has outputs");
                end
                if (count == 0 && cyc + 1 != first_pixel_cycles)
                begin
                    abort_run("the first pixel_valid did not come 12 cycles after start");
                end
                if (count > 0 && cyc - last_cyc != num_taps)
                begin
                    abort_run("pixel_valid pulses are not one window apart");
                end
                check_pixel(pixel_data, expected[count], $sformatf("pixel %0d", count));
                last_cyc = cyc;
                count++;
            end
        end
        while (!done);
        check_flag(pixel_valid, 1'b1, "pixel_valid with done");
        host_write = 1'b0;
        start      = 1'b0;
        if (count != num_outputs)
        begin
            abort_run($sformatf("done came after %0d pixels instead of %0d", count, num_outputs));
        end
        @(negedge clk);
        check_flag(busy, 1'b0, "busy after done");
    endtask

    task automatic test_reset_state();
        check_flag(busy, 1'b0, "busy after reset");
        check_flag(pixel_valid, 1'b0, "pixel_valid after reset");
        check_flag(done, 1'b0, "done after reset");
    endtask

    task automatic test_identity();
        word_t  ifm [ifm_words];
        word_t  wts [wm_words];
        word_t  bias [num_filters];
        pixel_t expected [num_outputs];
        int     i;
        for (i = 0; i < ifm_words; i++)
        begin
            ifm[i] = word_t'(i * 7 + 3);
        end
        for (i = 0; i < wm_words; i++)
        begin
            wts[i] = word_t'(i % num_taps == num_taps / 2); // centre tap only.
        end
        bias = '{default: '0};
        for (i = 0; i < num_outputs; i++)
        begin
            expected[i] = pixel_t'(ifm[(i / ofm_size % ofm_size + 1) * ifm_size
                + i % ofm_size + 1]);
        end
        load_ifm(ifm);
        load_kernels(wts);
        load_bias(bias);
        run_layer(expected, 1'b0);
    endtask

    task automatic test_random(input bit disturb);
        word_t  ifm [ifm_words];
        word_t  wts [wm_words];
        word_t  bias [num_filters];
        pixel_t expected [num_outputs];
        int     i;
        for (i = 0; i < ifm_words; i++)
        begin
            ifm[i] = random_between(-50, 50);
        end
        for (i = 0; i < wm_words; i++)
        begin
            wts[i] = random_between(-50, 50);
        end
        for (i = 0; i < num_filters; i++)
        begin
            bias[i] = random_between(-100, 100);
        end
        load_ifm(ifm);
        load_kernels(wts);
        load_bias(bias);
        model_layer(ifm_copy, wm_copy, bias_copy, expected);
        run_layer(expected, disturb);
        if (disturb)
        begin
            run_layer(expected, 1'b0); // memories must still hold the loaded data.
        end
    endtask

    task automatic test_relu();
        word_t  ifm [ifm_words];
        word_t  wts [wm_words];
        word_t  bias [num_filters];
        pixel_t expected [num_outputs];
        int     i;
        for (i = 0; i < ifm_words; i++)
        begin
            ifm[i] = word_t'(i % 10 + 1);
        end
        for (i = 0; i < wm_words; i++)
        begin
            wts[i] = word_t'(-(i % 4 + 1));
        end
        bias     = '{default: word_t'(2)}; // too small to lift any sum above zero.
        expected = '{default: '0};
        load_ifm(ifm);
        load_kernels(wts);
        load_bias(bias);
        run_layer(expected, 1'b0);
    endtask

    task automatic test_saturation();
        word_t  ifm [ifm_words];
        word_t  wts [wm_words];
        word_t  bias [num_filters];
        pixel_t expected [num_outputs];
        ifm      = '{default: word_t'(1000)};
        wts      = '{default: word_t'(1000)};
        bias     = '{default: '0};
        expected = '{default: pixel_t'(out_max)};
        load_ifm(ifm);
        load_kernels(wts);
        load_bias(bias);
        run_layer(expected, 1'b0);
    endtask

    initial
    begin
        void'($urandom(36));
        arst_n       = 1'b0;
        host_write   = 1'b0;
        host_address = '0;
        host_data    = '0;
        start        = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        test_reset_state();
        test_identity();
        test_random(1'b0);
        test_relu();
        test_saturation();
        test_random(1'b1);
        $display("Regression passed");
        $finish;
    end

endmodule

/* tb.f */
+incdir+include
hw/conv_pkg.sv
hw/conv_mem.sv
hw/conv_load.sv
hw/conv_window_seq.sv
hw/conv_mac.sv
hw/conv_activate.sv
hw/conv_layer_top.sv
tb/conv_layer_tb.sv

/* Bender.yml */
package:
  name: conv_layer

sources:
  - files:
      - hw/conv_pkg.sv
      - hw/conv_mem.sv
      - hw/conv_load.sv
      - hw/conv_window_seq.sv
      - hw/conv_mac.sv
      - hw/conv_activate.sv
      - hw/conv_layer_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/conv_layer_tb.sv
